/* Makefile */
# Verilator simulation of the I3C target receive path

VERILATOR ?= verilator
TOP       ?= tb_i3c_target_rx
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
common/i3c_pkg.sv
hdl/bus_monitor.sv
rx/bus_rx_flow.sv
rx/rx_framer.sv
hdl/i3c_target_rx.sv
testbench/i3c_target_rx_properties.sv
testbench/tb_i3c_target_rx.sv

/* common/i3c_pkg.sv */
// SDR receive path only. Frames are 8 data bits plus one T or ACK bit, and the address is 7 bits.
package i3c_pkg;

  // Target address without the RnW bit
  typedef logic [6:0] addr_t;

  // Bus byte, MSB first on the wire
  typedef logic [7:0] byte_t;

  // Bit position inside a 9-bit frame
  typedef logic [3:0] bit_cnt_t;

  // 8 data bits followed by ACK or T bit
  localparam bit_cnt_t BitsPerFrame = 4'd9;

  // Broadcast address, always accepted
  localparam addr_t BroadcastAddr = 7'h7E;

  // Depth of the SCL/SDA input synchronizers
  localparam int unsigned SyncStages = 2;

  // Framer FSM
  typedef enum logic [1:0] {
    Idle,
    Addr,
    Data,
    Ignore
  } framer_state_e;

endpackage

/* hdl/bus_monitor.sv */
`timescale 1ns/10ps
// SCL and SDA are asynchronous inputs. Every condition pulse lags the line change by SyncStages + 1 clocks.
module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_posedge_o,
  output logic sda_o,
  output logic start_det_o,
  output logic rstart_det_o,
  output logic stop_det_o
);
  import i3c_pkg::*;

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_sync;
  logic                  sda_sync;
  logic                  scl_q;
  logic                  sda_q;
  logic                  scl_rise;
  logic                  scl_high;
  logic                  start;
  logic                  stop;
  logic                  busy_q;

  assign scl_sync = scl_sync_q[SyncStages-1];
  assign sda_sync = sda_sync_q[SyncStages-1];

  // Both lines idle high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_q      <= scl_sync;
      sda_q      <= sda_sync;
    end
  end

  assign scl_rise = scl_sync & ~scl_q;
  assign scl_high = scl_sync & scl_q;

  // SDA edges while SCL is held high
  assign start = scl_high & sda_q & ~sda_sync;
  assign stop  = scl_high & ~sda_q & sda_sync;

  // sda_q lines up with the registered SCL edge
  assign sda_o = sda_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q        <= 1'b0;
      scl_posedge_o <= 1'b0;
      start_det_o   <= 1'b0;
      rstart_det_o  <= 1'b0;
      stop_det_o    <= 1'b0;
    end else begin
      scl_posedge_o <= scl_rise;
      start_det_o   <= start & ~busy_q;
      rstart_det_o  <= start & busy_q;
      stop_det_o    <= stop;
      if (start) begin
        busy_q <= 1'b1;
      end else if (stop) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

/* hdl/i3c_target_rx.sv */
`timescale 1ns/10ps
// Receive only. The target never drives SDA, so the controller must supply ACK and T bits itself.
module i3c_target_rx (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           scl_i,
  input  logic           sda_i,
  input  i3c_pkg::addr_t sta_addr_i,
  input  i3c_pkg::addr_t dyn_addr_i,
  input  logic           dyn_addr_valid_i,
  input  logic           rx_ready_i,
  output logic           bus_start_o,
  output logic           bus_rstart_o,
  output logic           bus_stop_o,
  output i3c_pkg::byte_t bus_addr_o,
  output logic           bus_addr_valid_o,
  output logic           addr_match_o,
  output logic           rx_valid_o,
  output i3c_pkg::byte_t rx_data_o,
  output logic           parity_err_o,
  output logic           overflow_o
);
  import i3c_pkg::*;

  logic  scl_posedge;
  logic  sda_sync;
  logic  frame_start;
  logic  frame_valid;
  byte_t frame_byte;
  logic  frame_ninth;

  // Any START restarts framing
  assign frame_start = bus_start_o | bus_rstart_o;

  bus_monitor i_bus_monitor (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .scl_posedge_o (scl_posedge),
    .sda_o         (sda_sync),
    .start_det_o   (bus_start_o),
    .rstart_det_o  (bus_rstart_o),
    .stop_det_o    (bus_stop_o)
  );

  bus_rx_flow i_bus_rx_flow (
    .clk_i,
    .rst_ni,
    .scl_posedge_i (scl_posedge),
    .sda_i         (sda_sync),
    .frame_start_i (frame_start),
    .frame_valid_o (frame_valid),
    .frame_byte_o  (frame_byte),
    .frame_ninth_o (frame_ninth)
  );

  rx_framer i_rx_framer (
    .clk_i,
    .rst_ni,
    .start_det_i   (frame_start),
    .stop_det_i    (bus_stop_o),
    .frame_valid_i (frame_valid),
    .frame_byte_i  (frame_byte),
    .frame_ninth_i (frame_ninth),
    .sta_addr_i,
    .dyn_addr_i,
    .dyn_addr_valid_i,
    .rx_ready_i,
    .bus_addr_o,
    .bus_addr_valid_o,
    .addr_match_o,
    .rx_valid_o,
    .rx_data_o,
    .parity_err_o,
    .overflow_o
  );

endmodule

/* rx/bus_rx_flow.sv */
`timescale 1ns/10ps
// Expects synchronized inputs from bus_monitor. Frames are MSB first and are not checked for length at STOP.
module bus_rx_flow (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           scl_posedge_i,
  input  logic           sda_i,
  input  logic           frame_start_i,
  output logic           frame_valid_o,
  output i3c_pkg::byte_t frame_byte_o,
  output logic           frame_ninth_o
);
  import i3c_pkg::*;

  bit_cnt_t bit_cnt_q;
  byte_t    shift_q;
  logic     last_bit;

  assign last_bit = (bit_cnt_q == BitsPerFrame - bit_cnt_t'(1));

  // Bit counter wraps so frames can follow back to back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q     <= '0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= 1'b0;
      if (frame_start_i) begin
        bit_cnt_q <= '0;
      end else if (scl_posedge_i) begin
        if (last_bit) begin
          bit_cnt_q     <= '0;
          frame_valid_o <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + bit_cnt_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_posedge_i) begin
      if (last_bit) begin
        // Ninth bit taken straight from SDA
        frame_byte_o  <= shift_q;
        frame_ninth_o <= sda_i;
      end else begin
        shift_q <= {shift_q[6:0], sda_i};
      end
    end
  end

endmodule

/* rx/rx_framer.sv */
`timescale 1ns/10ps
// Holds one received byte. Bytes that arrive while it is full are dropped and set the sticky overflow flag.
module rx_framer (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           start_det_i,
  input  logic           stop_det_i,
  input  logic           frame_valid_i,
  input  i3c_pkg::byte_t frame_byte_i,
  input  logic           frame_ninth_i,
  input  i3c_pkg::addr_t sta_addr_i,
  input  i3c_pkg::addr_t dyn_addr_i,
  input  logic           dyn_addr_valid_i,
  input  logic           rx_ready_i,
  output i3c_pkg::byte_t bus_addr_o,
  output logic           bus_addr_valid_o,
  output logic           addr_match_o,
  output logic           rx_valid_o,
  output i3c_pkg::byte_t rx_data_o,
  output logic           parity_err_o,
  output logic           overflow_o
);
  import i3c_pkg::*;

  framer_state_e state_q;
  framer_state_e state_d;
  addr_t         frame_addr;
  logic          frame_rnw;
  logic          addr_hit;
  logic          addr_frame;
  logic          data_frame;
  logic          parity_ok;
  logic          buf_free;
  logic          accept;

  assign frame_addr = frame_byte_i[7:1];
  assign frame_rnw  = frame_byte_i[0];

  // Dynamic address replaces the static one once assigned
  always_comb begin
    if (frame_addr == BroadcastAddr) begin
      addr_hit = 1'b1;
    end else if (dyn_addr_valid_i) begin
      addr_hit = (frame_addr == dyn_addr_i);
    end else begin
      addr_hit = (frame_addr == sta_addr_i);
    end
  end

  assign addr_frame = frame_valid_i & (state_q == Addr);
  assign data_frame = frame_valid_i & (state_q == Data);

  // Odd parity over byte and T bit
  assign parity_ok = ^{frame_byte_i, frame_ninth_i};
  assign buf_free  = ~rx_valid_o | rx_ready_i;
  assign accept    = data_frame & parity_ok & buf_free;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Addr: begin
        if (frame_valid_i) begin
          state_d = (addr_hit && !frame_rnw) ? Data : Ignore;
        end
      end
      default: ;
    endcase
    if (stop_det_i) begin
      state_d = Idle;
    end
    if (start_det_i) begin
      state_d = Addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= Idle;
      bus_addr_valid_o <= 1'b0;
      addr_match_o     <= 1'b0;
      parity_err_o     <= 1'b0;
      rx_valid_o       <= 1'b0;
      overflow_o       <= 1'b0;
    end else begin
      state_q          <= state_d;
      bus_addr_valid_o <= addr_frame;
      addr_match_o     <= addr_frame & addr_hit;
      parity_err_o     <= data_frame & ~parity_ok;
      if (accept) begin
        rx_valid_o <= 1'b1;
      end else if (rx_ready_i) begin
        rx_valid_o <= 1'b0;
      end
      if (data_frame && parity_ok && !buf_free) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (addr_frame) begin
      bus_addr_o <= frame_byte_i;
    end
    if (accept) begin
      rx_data_o <= frame_byte_i;
    end
  end

endmodule

/* testbench/i3c_target_rx_properties.sv */
`timescale 1ns/10ps
// Bound to every i3c_target_rx instance. Checks only output protocol and ignores the cycles in reset.
module i3c_target_rx_properties (
  input logic           clk_i,
  input logic           rst_ni,
  input logic           rx_ready_i,
  input logic           rx_valid_o,
  input i3c_pkg::byte_t rx_data_o,
  input logic           bus_start_o,
  input logic           bus_rstart_o,
  input logic           bus_stop_o,
  input logic           bus_addr_valid_o
);

  // Held byte must not move until it is taken
  rx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable(rx_data_o))
    else $error("rx_data_o changed or valid dropped before ready");

  start_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_start_o |=> !bus_start_o)
    else $error("bus_start_o longer than one cycle");

  rstart_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rstart_o |=> !bus_rstart_o)
    else $error("bus_rstart_o longer than one cycle");

  stop_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stop_o |=> !bus_stop_o)
    else $error("bus_stop_o longer than one cycle");

  addr_vs_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_addr_valid_o && bus_start_o))
    else $error("bus_addr_valid_o together with bus_start_o");

endmodule

bind i3c_target_rx i3c_target_rx_properties i_i3c_target_rx_properties (.*);

/* testbench/tb_i3c_target_rx.sv */
`timescale 1ns/10ps
// Plays the I3C controller on SCL/SDA with 16 clocks per SCL phase. Stops at the first mismatch.
module tb_i3c_target_rx;
  import i3c_pkg::*;

  localparam int unsigned Phase     = 16;
  localparam int unsigned MaxCycles = 30000;
  localparam addr_t       StaAddr   = 7'h15;
  localparam addr_t       DynAddr   = 7'h2A;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  scl_i;
  logic  sda_i;
  logic  dyn_addr_valid_i;
  logic  rx_ready_i;
  addr_t sta_addr_i;
  addr_t dyn_addr_i;
  logic  bus_start_o;
  logic  bus_rstart_o;
  logic  bus_stop_o;
  logic  bus_addr_valid_o;
  logic  addr_match_o;
  logic  rx_valid_o;
  logic  parity_err_o;
  logic  overflow_o;
  byte_t bus_addr_o;
  byte_t rx_data_o;

  int unsigned cycles = 0;
  int          n_start;
  int          n_rstart;
  int          n_stop;
  int          n_match;
  int          n_parity;
  byte_t       addr_q[$];
  byte_t       rx_q[$];
  byte_t       b[3];

  i3c_target_rx i_i3c_target_rx (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run exceeded %0d cycles", MaxCycles);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // Observed DUT responses
  always @(posedge clk_i) begin
    if (bus_start_o) n_start++;
    if (bus_rstart_o) n_rstart++;
    if (bus_stop_o) n_stop++;
    if (addr_match_o) n_match++;
    if (parity_err_o) n_parity++;
    if (bus_addr_valid_o) addr_q.push_back(bus_addr_o);
    if (rx_valid_o && rx_ready_i) rx_q.push_back(rx_data_o);
  end

  task automatic fail_check(string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic check_addr(string what, byte_t got, byte_t exp);
    if (got !== exp) fail_check($sformatf("%s: address %h, expected %h", what, got, exp));
  endtask

  task automatic check_data(string what, byte_t got, byte_t exp);
    if (got !== exp) fail_check($sformatf("%s: data %h, expected %h", what, got, exp));
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) fail_check($sformatf("%s: flag %b, expected %b", what, got, exp));
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp) fail_check($sformatf("%s: count %0d, expected %0d", what, got, exp));
  endtask

  task automatic clear_observed();
    n_start = 0;
    n_rstart = 0;
    n_stop = 0;
    n_match = 0;
    n_parity = 0;
    addr_q.delete();
    rx_q.delete();
  endtask

  task automatic wait_cycles(int unsigned n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic start_cond();
    sda_i = 1'b0;
    wait_cycles(Phase);
    scl_i = 1'b0;
    wait_cycles(Phase);
  endtask

  task automatic rstart_cond();
    sda_i = 1'b1;
    wait_cycles(Phase);
    scl_i = 1'b1;
    wait_cycles(Phase);
    start_cond();
  endtask

  task automatic stop_cond();
    sda_i = 1'b0;
    wait_cycles(Phase);
    scl_i = 1'b1;
    wait_cycles(Phase);
    sda_i = 1'b1;
    wait_cycles(4 * Phase);
  endtask

  task automatic send_frame(byte_t data, logic ninth);
    logic [8:0] bits;
    bits = {data, ninth};
    for (int i = 8; i >= 0; i--) begin
      sda_i = bits[i];
      wait_cycles(Phase);
      scl_i = 1'b1;
      wait_cycles(Phase);
      scl_i = 1'b0;
    end
    wait_cycles(Phase);
  endtask

  // T bit makes the count of ones odd unless inverted on purpose
  task automatic send_data(byte_t data, logic bad_parity);
    logic t;
    t = ~(^data);
    send_frame(data, bad_parity ? ~t : t);
  endtask

  task automatic test_conditions();
    clear_observed();
    start_cond();
    send_frame({StaAddr, 1'b0}, 1'b0);
    stop_cond();
    check_count("t1 start", n_start, 1);
    check_count("t1 stop", n_stop, 1);
    check_count("t1 rstart", n_rstart, 0);
  endtask

  task automatic test_dyn_write();
    clear_observed();
    dyn_addr_valid_i = 1'b1;
    foreach (b[i]) b[i] = byte_t'($urandom);
    start_cond();
    send_frame({DynAddr, 1'b0}, 1'b0);
    foreach (b[i]) send_data(b[i], 1'b0);
    stop_cond();
    check_count("t2 addr reports", addr_q.size(), 1);
    check_addr("t2 addr", addr_q[0], {DynAddr, 1'b0});
    check_count("t2 match", n_match, 1);
    check_count("t2 bytes", rx_q.size(), 3);
    foreach (b[i]) check_data("t2 byte", rx_q[i], b[i]);
  endtask

  task automatic test_mismatch_read();
    clear_observed();
    start_cond();
    send_frame({7'h33, 1'b0}, 1'b0);
    send_data(8'hA5, 1'b0);
    stop_cond();
    check_count("t3 foreign addr reports", addr_q.size(), 1);
    check_count("t3 foreign match", n_match, 0);
    check_count("t3 foreign bytes", rx_q.size(), 0);
    clear_observed();
    dyn_addr_valid_i = 1'b0;
    start_cond();
    send_frame({StaAddr, 1'b0}, 1'b0);
    send_data(8'h3C, 1'b0);
    stop_cond();
    check_count("t3 static match", n_match, 1);
    check_count("t3 static bytes", rx_q.size(), 1);
    check_data("t3 static byte", rx_q[0], 8'h3C);
    clear_observed();
    start_cond();
    send_frame({StaAddr, 1'b1}, 1'b0);
    send_data(8'h5A, 1'b0);
    stop_cond();
    check_addr("t3 read addr", addr_q[0], {StaAddr, 1'b1});
    check_count("t3 read bytes", rx_q.size(), 0);
  endtask

  task automatic test_broadcast_rstart();
    clear_observed();
    dyn_addr_valid_i = 1'b1;
    start_cond();
    send_frame({BroadcastAddr, 1'b0}, 1'b0);
    rstart_cond();
    send_frame({DynAddr, 1'b0}, 1'b0);
    stop_cond();
    check_count("t4 rstart", n_rstart, 1);
    check_count("t4 addr reports", addr_q.size(), 2);
    check_addr("t4 first addr", addr_q[0], {BroadcastAddr, 1'b0});
    check_addr("t4 second addr", addr_q[1], {DynAddr, 1'b0});
    check_count("t4 match", n_match, 2);
  endtask

  task automatic test_parity();
    clear_observed();
    foreach (b[i]) b[i] = byte_t'($urandom);
    start_cond();
    send_frame({DynAddr, 1'b0}, 1'b0);
    send_data(b[0], 1'b0);
    send_data(b[1], 1'b1);
    send_data(b[2], 1'b0);
    stop_cond();
    check_count("t5 parity errors", n_parity, 1);
    check_count("t5 bytes", rx_q.size(), 2);
    check_data("t5 first byte", rx_q[0], b[0]);
    check_data("t5 second byte", rx_q[1], b[2]);
  endtask

  task automatic test_backpressure();
    clear_observed();
    check_flag("t6 overflow before stall", overflow_o, 1'b0);
    rx_ready_i = 1'b0;
    foreach (b[i]) b[i] = byte_t'($urandom);
    start_cond();
    send_frame({DynAddr, 1'b0}, 1'b0);
    send_data(b[0], 1'b0);
    send_data(b[1], 1'b0);
    stop_cond();
    check_flag("t6 overflow", overflow_o, 1'b1);
    check_count("t6 bytes while stalled", rx_q.size(), 0);
    rx_ready_i = 1'b1;
    while (rx_q.size() == 0) @(posedge clk_i);
    wait_cycles(Phase);
    check_count("t6 bytes after ready", rx_q.size(), 1);
    check_data("t6 byte", rx_q[0], b[0]);
    check_flag("t6 valid after drain", rx_valid_o, 1'b0);
  endtask

  initial begin
    void'($urandom(6454));
    rst_ni = 1'b0;
    scl_i = 1'b1;
    sda_i = 1'b1;
    sta_addr_i = StaAddr;
    dyn_addr_i = DynAddr;
    dyn_addr_valid_i = 1'b0;
    rx_ready_i = 1'b1;
    clear_observed();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_cycles(Phase);
    test_conditions();
    test_dyn_write();
    test_mismatch_read();
    test_broadcast_rstart();
    test_parity();
    test_backpressure();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
